//--- design/mam_apb_ctrl.sv
// APB register file and Wishbone single-cycle master of the debug memory access unit
`timescale 1ns/1ps
`include "mam_consts.svh"

module mam_apb_ctrl (
   input  logic              wb_in_clk_i,
   input  logic              wb_in_rst_i,
   // Debug host
   input  mam_pkg::apb_req_t apb_req_i,
   output mam_pkg::apb_rsp_t apb_rsp_o,
   // Wishbone master toward the adapter
   output wb_pkg::wb_req_t   wb_mam_req_o,
   input  wb_pkg::wb_rsp_t   wb_mam_rsp_i
);

   import wb_pkg::*;
   import mam_pkg::*;

   mam_state_e state_q;

   // Command registers, loaded by the host
   wb_adr_t addr_q;
   wb_dat_t wdata_q;
   wb_sel_t sel_q;
   logic    we_q;

   // Result registers
   wb_dat_t rdata_q;
   logic    err_q;

   logic    busy;
   logic    bus_done;
   logic    apb_access;
   logic    apb_wr;

   // Register decode
   logic    hit_addr;
   logic    hit_wdata;
   logic    hit_ctrl;
   logic    hit_rdata;
   logic    hit_status;
   logic    hit_any;

   wb_dat_t rd_mux;

   assign busy     = (state_q == MAM_BUS);
   assign bus_done = busy & (wb_mam_rsp_i.ack | wb_mam_rsp_i.err);

   // Only the access phase does anything
   assign apb_access = apb_req_i.psel & apb_req_i.penable;
   assign apb_wr     = apb_access & apb_req_i.pwrite;

   assign hit_addr   = (apb_req_i.paddr == `MAM_REG_ADDR);
   assign hit_wdata  = (apb_req_i.paddr == `MAM_REG_WDATA);
   assign hit_ctrl   = (apb_req_i.paddr == `MAM_REG_CTRL);
   assign hit_rdata  = (apb_req_i.paddr == `MAM_REG_RDATA);
   assign hit_status = (apb_req_i.paddr == `MAM_REG_STATUS);
   assign hit_any    = hit_addr | hit_wdata | hit_ctrl | hit_rdata | hit_status;

   // Command FSM
   always_ff @(posedge wb_in_clk_i) begin
      if (wb_in_rst_i) begin
         state_q <= MAM_IDLE;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            MAM_IDLE: begin
               // CTRL write launches the bus cycle on the next clock
               if (apb_wr && hit_ctrl) begin
                  state_q <= MAM_BUS;
                  err_q   <= 1'b0;
               end
            end
            MAM_BUS: begin
               // Back to idle after ack or err, busy drops the cycle after
               if (bus_done) begin
                  state_q <= MAM_IDLE;
                  err_q   <= wb_mam_rsp_i.err;
               end
            end
            default: begin
               state_q <= MAM_IDLE;
            end
         endcase
      end
   end

   // Host writes and read capture
   always_ff @(posedge wb_in_clk_i) begin
      // Command fields frozen while busy so the request stays stable
      if (apb_wr && !busy) begin
         if (hit_addr) begin
            addr_q <= apb_req_i.pwdata;
         end
         if (hit_wdata) begin
            wdata_q <= apb_req_i.pwdata;
         end
         if (hit_ctrl) begin
            we_q  <= apb_req_i.pwdata[0];
            sel_q <= apb_req_i.pwdata[7:4];
         end
      end
      if (bus_done && wb_mam_rsp_i.ack && !we_q) begin
         rdata_q <= wb_mam_rsp_i.dat;
      end
   end

   // Readback mux
   always_comb begin
      rd_mux = '0;
      if (hit_addr) begin
         rd_mux = addr_q;
      end else if (hit_wdata) begin
         rd_mux = wdata_q;
      end else if (hit_ctrl) begin
         rd_mux[7:4] = sel_q;
         rd_mux[0]   = we_q;
      end else if (hit_rdata) begin
         rd_mux = rdata_q;
      end else if (hit_status) begin
         rd_mux[1] = err_q;
         rd_mux[0] = busy;
      end
   end

   // No wait states, unmapped offsets flagged
   assign apb_rsp_o.pready  = 1'b1;
   assign apb_rsp_o.pslverr = apb_access & ~hit_any;
   assign apb_rsp_o.prdata  = rd_mux;

   // Single cycle request, cyc and stb follow the state
   assign wb_mam_req_o.cyc = busy;
   assign wb_mam_req_o.stb = busy;
   assign wb_mam_req_o.we  = we_q;
   assign wb_mam_req_o.adr = addr_q;
   assign wb_mam_req_o.sel = sel_q;
   assign wb_mam_req_o.dat = wdata_q;

endmodule

//--- design/mam_consts.svh
// Bus widths, SRAM depth and APB register offsets of the debug memory subsystem
`ifndef MAM_CONSTS_SVH
`define MAM_CONSTS_SVH

// Wishbone byte address width
`define MAM_AW 32

// Wishbone data width
`define MAM_DW 32

// One select bit per data byte
`define MAM_SW 4

// Depth of the single-port SRAM in data words
`define SRAM_WORDS 256

// APB register map of the MAM, byte offsets
`define MAM_REG_ADDR   8'h00
`define MAM_REG_WDATA  8'h04
`define MAM_REG_CTRL   8'h08
`define MAM_REG_RDATA  8'h0C
`define MAM_REG_STATUS 8'h10

`endif

//--- design/mam_mem_top.sv
// Top level with CPU port, APB debug port, MAM, Wishbone adapter and SRAM
`timescale 1ns/1ps

module mam_mem_top (
   input  logic              wb_in_clk_i,
   input  logic              wb_in_rst_i,
   // CPU Wishbone master port
   input  wb_pkg::wb_req_t   wb_cpu_req_i,
   output wb_pkg::wb_rsp_t   wb_cpu_rsp_o,
   // Debug host APB port
   input  mam_pkg::apb_req_t apb_req_i,
   output mam_pkg::apb_rsp_t apb_rsp_o
);

   import wb_pkg::*;

   // MAM master to adapter
   wb_req_t wb_mam_req;
   wb_rsp_t wb_mam_rsp;

   // Adapter to memory slave
   wb_req_t wb_mem_req;
   wb_rsp_t wb_mem_rsp;

   // Debug access unit programmed over APB
   mam_apb_ctrl u_mam (
      .wb_in_clk_i  (wb_in_clk_i),
      .wb_in_rst_i  (wb_in_rst_i),
      .apb_req_i    (apb_req_i),
      .apb_rsp_o    (apb_rsp_o),
      .wb_mam_req_o (wb_mam_req),
      .wb_mam_rsp_i (wb_mam_rsp)
   );

   // Arbitration between CPU and MAM
   mam_wb_adapter u_adapter (
      .wb_in_clk_i  (wb_in_clk_i),
      .wb_in_rst_i  (wb_in_rst_i),
      .wb_cpu_req_i (wb_cpu_req_i),
      .wb_cpu_rsp_o (wb_cpu_rsp_o),
      .wb_mam_req_i (wb_mam_req),
      .wb_mam_rsp_o (wb_mam_rsp),
      .wb_mem_req_o (wb_mem_req),
      .wb_mem_rsp_i (wb_mem_rsp)
   );

   // Shared memory, default depth
   wb_sram u_sram (
      .wb_in_clk_i (wb_in_clk_i),
      .wb_in_rst_i (wb_in_rst_i),
      .wb_req_i    (wb_mem_req),
      .wb_rsp_o    (wb_mem_rsp)
   );

endmodule

//--- design/mam_pkg.sv
// APB request and response structs, MAM state enum for the debug side
`include "mam_consts.svh"

package mam_pkg;

   // APB register offset, byte granular
   typedef logic [7:0] apb_addr_t;

   // Setup cycle has psel only, access cycle adds penable
   typedef struct packed {
      logic                psel;
      logic                penable;
      logic                pwrite;
      apb_addr_t           paddr;
      logic [`MAM_DW-1:0]  pwdata;
   } apb_req_t;

   // Sampled by the host in the access cycle
   typedef struct packed {
      logic                pready;
      logic                pslverr;
      logic [`MAM_DW-1:0]  prdata;
   } apb_rsp_t;

   // Idle, or one Wishbone single cycle in flight
   typedef enum logic {
      MAM_IDLE = 1'b0,
      MAM_BUS  = 1'b1
   } mam_state_e;

endpackage

//--- design/mam_wb_adapter.sv
// Arbiter and request/response multiplexer between the CPU and MAM Wishbone masters
`timescale 1ns/1ps

module mam_wb_adapter (
   input  logic            wb_in_clk_i,
   input  logic            wb_in_rst_i,
   // CPU master
   input  wb_pkg::wb_req_t wb_cpu_req_i,
   output wb_pkg::wb_rsp_t wb_cpu_rsp_o,
   // Debug MAM master
   input  wb_pkg::wb_req_t wb_mam_req_i,
   output wb_pkg::wb_rsp_t wb_mam_rsp_o,
   // Memory slave
   output wb_pkg::wb_req_t wb_mem_req_o,
   input  wb_pkg::wb_rsp_t wb_mem_rsp_i
);

   import wb_pkg::*;

   arb_state_e state_q;
   arb_state_e state_d;

   // Grants come out of the state, not out of the requests
   logic grant_cpu;
   logic grant_mam;

   // Sticky routing select, 1 means the CPU owns the memory port
   logic access_cpu;

   // State register and routing bit
   always_ff @(posedge wb_in_clk_i) begin
      if (wb_in_rst_i) begin
         state_q    <= ARB_IDLE;
         access_cpu <= 1'b0;
      end else begin
         state_q <= state_d;
         // Routing follows the grant one cycle later
         if (grant_cpu) begin
            access_cpu <= 1'b1;
         end else if (grant_mam) begin
            access_cpu <= 1'b0;
         end
      end
   end

   // Next state, MAM wins from idle
   always_comb begin
      state_d   = ARB_IDLE;
      grant_cpu = 1'b0;
      grant_mam = 1'b0;
      case (state_q)
         ARB_IDLE: begin
            if (wb_mam_req_i.cyc) begin
               state_d = ARB_MAM;
            end else if (wb_cpu_req_i.cyc) begin
               state_d = ARB_CPU;
            end
         end
         ARB_MAM: begin
            grant_mam = 1'b1;
            // MAM keeps the port until it releases cyc
            if (wb_mam_req_i.cyc) begin
               state_d = ARB_MAM;
            end
         end
         ARB_CPU: begin
            grant_cpu = 1'b1;
            // CPU is never pre-empted, a waiting MAM gets the port straight after
            if (wb_cpu_req_i.cyc) begin
               state_d = ARB_CPU;
            end else if (wb_mam_req_i.cyc) begin
               state_d = ARB_MAM;
            end
         end
         default: begin
            state_d = ARB_IDLE;
         end
      endcase
   end

   // Whole request struct toward the memory
   // MAM request passes even before its grant while routing points to it
   assign wb_mem_req_o = access_cpu ? wb_cpu_req_i : wb_mam_req_i;

   // Responses only to the routed master
   // the other one sees ack, err and data held at zero
   assign wb_cpu_rsp_o = access_cpu ? wb_mem_rsp_i : '0;
   assign wb_mam_rsp_o = access_cpu ? '0 : wb_mem_rsp_i;

endmodule

//--- design/wb_pkg.sv
// Wishbone vector typedefs, request and response structs, arbiter state enum
`include "mam_consts.svh"

package wb_pkg;

   // Byte address as driven by a master
   typedef logic [`MAM_AW-1:0] wb_adr_t;

   // One data word
   typedef logic [`MAM_DW-1:0] wb_dat_t;

   // Byte lane enables
   typedef logic [`MAM_SW-1:0] wb_sel_t;

   // Everything a master drives toward a slave
   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      wb_sel_t sel;
      wb_dat_t dat;
   } wb_req_t;

   // Everything a slave returns, ack and err are one-cycle pulses
   typedef struct packed {
      logic    ack;
      logic    err;
      wb_dat_t dat;
   } wb_rsp_t;

   // Ownership of the shared memory port
   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      ARB_MAM  = 2'd1,
      ARB_CPU  = 2'd2
   } arb_state_e;

endpackage

//--- design/wb_sram.sv
// Wishbone slave single-port SRAM with byte lane writes and out-of-range error
`timescale 1ns/1ps
`include "mam_consts.svh"

module wb_sram #(
   parameter int MEM_WORDS = `SRAM_WORDS
) (
   input  logic            wb_in_clk_i,
   input  logic            wb_in_rst_i,
   input  wb_pkg::wb_req_t wb_req_i,
   output wb_pkg::wb_rsp_t wb_rsp_o
);

   import wb_pkg::*;

   // Low address bits pick the byte inside a word
   localparam int BYTE_AW = $clog2(`MAM_SW);
   localparam int IDX_W   = $clog2(MEM_WORDS);

   wb_dat_t mem [MEM_WORDS];

   logic [`MAM_AW-BYTE_AW-1:0] word_idx;
   logic [IDX_W-1:0]           mem_idx;
   logic                       in_range;
   logic                       req_new;

   logic    ack_q;
   logic    err_q;
   wb_dat_t rdata_q;

   assign word_idx = wb_req_i.adr[`MAM_AW-1:BYTE_AW];
   assign mem_idx  = word_idx[IDX_W-1:0];
   assign in_range = (word_idx < MEM_WORDS);

   // One response per request, the ack cycle itself blocks a second one
   assign req_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q & ~err_q;

   // Response pulses
   always_ff @(posedge wb_in_clk_i) begin
      if (wb_in_rst_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req_new & in_range;
         err_q <= req_new & ~in_range;
      end
   end

   // Array access, read returns the word before this write
   always_ff @(posedge wb_in_clk_i) begin
      if (req_new && in_range) begin
         rdata_q <= mem[mem_idx];
         if (wb_req_i.we) begin
            for (int b = 0; b < `MAM_SW; b++) begin
               if (wb_req_i.sel[b]) begin
                  mem[mem_idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
               end
            end
         end
      end
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.err = err_q;
   assign wb_rsp_o.dat = rdata_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if TEST OK is printed
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mam_mem; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mam_mem 2>&1)
rc=$?
echo "$out"

if [ $rc -ne 0 ]; then
    echo "Simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+design
design/wb_pkg.sv
design/mam_pkg.sv
design/mam_wb_adapter.sv
design/mam_apb_ctrl.sv
design/wb_sram.sv
design/mam_mem_top.sv
verification/tb_mam_mem.sv

//--- verification/tb_mam_mem.sv
// Testbench for mam_mem_top with CPU and APB drivers, reference memory, checks and timeout
`timescale 1ns/1ps
`include "mam_consts.svh"

module tb_mam_mem;

   import wb_pkg::*;
   import mam_pkg::*;

   // About 700 accesses at a worst case of 20 cycles, plus margin
   localparam int CYCLE_LIMIT = 20000;
   localparam int RAND_OPS    = 40;
   localparam int DBG_OPS     = 8;

   logic     clk;
   logic     rst;
   wb_req_t  cpu_req;
   wb_rsp_t  cpu_rsp;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;

   // Reference copy of the SRAM
   wb_dat_t  model [`SRAM_WORDS];
   logic [31:0] rng_state;
   int       cycles;
   logic     cpu_open;
   int       cpu_ack_cycle;
   int       mam_done_cycle;

   mam_mem_top UUT (
      .wb_in_clk_i  (clk),
      .wb_in_rst_i  (rst),
      .wb_cpu_req_i (cpu_req),
      .wb_cpu_rsp_o (cpu_rsp),
      .apb_req_i    (apb_req),
      .apb_rsp_o    (apb_rsp)
   );

   always #4 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else mismatch(name, exp, act);
   endtask

   // Cycle counter ends a stuck run
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         abort_run("Timeout, the run exceeded its cycle limit");
      end
   end

   // Responses only reach the master that owns an open cycle
   always @(negedge clk) begin
      if (!cpu_open) begin
         assert (!(cpu_rsp.ack || cpu_rsp.err))
            else abort_run("CPU port saw ack or err with no cycle open");
      end
      if (!UUT.u_mam.busy) begin
         assert (!(UUT.wb_mam_rsp.ack || UUT.wb_mam_rsp.err))
            else abort_run("MAM saw ack or err while idle");
      end
      if (cpu_rsp.ack || cpu_rsp.err) begin
         cpu_ack_cycle = cycles;
      end
      if (UUT.wb_mam_rsp.ack || UUT.wb_mam_rsp.err) begin
         mam_done_cycle = cycles;
      end
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Byte lanes with sel set take the new data
   function automatic wb_dat_t merge_bytes(input wb_dat_t old, input wb_dat_t nw,
                                           input wb_sel_t sel);
      wb_dat_t res;
      res = old;
      for (int b = 0; b < `MAM_SW; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = nw[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic cpu_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                             input wb_dat_t dat, output wb_dat_t rd, output logic err);
      @(posedge clk);
      cpu_req.cyc <= 1'b1;
      cpu_req.stb <= 1'b1;
      cpu_req.we  <= we;
      cpu_req.adr <= adr;
      cpu_req.sel <= sel;
      cpu_req.dat <= dat;
      cpu_open = 1'b1;
      do @(negedge clk); while (!(cpu_rsp.ack || cpu_rsp.err));
      rd  = cpu_rsp.dat;
      err = cpu_rsp.err;
      @(posedge clk);
      cpu_req.cyc <= 1'b0;
      cpu_req.stb <= 1'b0;
      cpu_open = 1'b0;
   endtask

   task automatic cpu_write(input string name, input int idx, input wb_sel_t sel,
                            input wb_dat_t dat);
      wb_dat_t rd;
      logic    err;
      cpu_access(1'b1, wb_adr_t'(idx * 4), sel, dat, rd, err);
      check_value(name, 0, err);
      model[idx] = merge_bytes(model[idx], dat, sel);
   endtask

   task automatic cpu_read_check(input string name, input int idx);
      wb_dat_t rd;
      logic    err;
      cpu_access(1'b0, wb_adr_t'(idx * 4), 4'hF, '0, rd, err);
      check_value({name, " err"}, 0, err);
      check_value(name, model[idx], rd);
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] addr, input wb_dat_t wdata,
                             output wb_dat_t rdata, output logic slverr);
      @(posedge clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= wr;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      rdata  = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      // No wait states on the debug port
      check_value("apb pready", 1, apb_rsp.pready);
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input wb_dat_t wdata);
      wb_dat_t rd;
      logic    slverr;
      apb_access(1'b1, addr, wdata, rd, slverr);
      check_value("apb write slverr", 0, slverr);
   endtask

   task automatic apb_read(input logic [7:0] addr, output wb_dat_t rd);
      logic slverr;
      apb_access(1'b0, addr, '0, rd, slverr);
      check_value("apb read slverr", 0, slverr);
   endtask

   task automatic mam_setup(input wb_adr_t adr, input wb_dat_t dat);
      apb_write(`MAM_REG_ADDR, adr);
      apb_write(`MAM_REG_WDATA, dat);
   endtask

   task automatic mam_start(input logic we, input wb_sel_t sel);
      apb_write(`MAM_REG_CTRL, {24'h0, sel, 3'b000, we});
   endtask

   // Polls STATUS until busy drops, then fetches RDATA
   task automatic mam_finish(input logic check_busy, output wb_dat_t rd, output logic err);
      wb_dat_t st;
      apb_read(`MAM_REG_STATUS, st);
      if (check_busy) begin
         check_value("mam busy after ctrl", 1, st[0]);
      end
      while (st[0]) begin
         apb_read(`MAM_REG_STATUS, st);
      end
      err = st[1];
      apb_read(`MAM_REG_RDATA, rd);
   endtask

   initial begin
      wb_dat_t rd;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    err;
      int      idx;
      int      idx2;
      clk = 1'b0;
      rst = 1'b1;
      cpu_req = '0;
      apb_req = '0;
      cycles = 0;
      cpu_open = 1'b0;
      cpu_ack_cycle = 0;
      mam_done_cycle = 0;
      rng_state = 32'h176a;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("reset cpu ack", 0, cpu_rsp.ack);
      check_value("reset cpu err", 0, cpu_rsp.err);
      apb_read(`MAM_REG_STATUS, rd);
      check_value("reset status", 0, rd[1:0]);

      // Fill pattern built from the whole byte address
      for (int i = 0; i < `SRAM_WORDS; i++) begin
         model[i] = 'x;
         cpu_write("fill", i, 4'hF, (i * 4) ^ 32'h5a3c_0000 ^ ((i * 4) << 20));
      end

      // CPU path with random lanes
      for (int i = 0; i < RAND_OPS; i++) begin
         idx = next_random() % `SRAM_WORDS;
         sel = next_random();
         cpu_write("cpu rand write", idx, sel, next_random());
         cpu_read_check("cpu rand read", next_random() % `SRAM_WORDS);
      end

      // MAM writes seen by the CPU, CPU writes seen in RDATA
      for (int i = 0; i < DBG_OPS; i++) begin
         idx = next_random() % `SRAM_WORDS;
         dat = next_random();
         sel = next_random();
         mam_setup(wb_adr_t'(idx * 4), dat);
         mam_start(1'b1, sel);
         // Routing may still point to the MAM, then the write is done in one cycle
         mam_finish(1'b0, rd, err);
         check_value("mam write err", 0, err);
         model[idx] = merge_bytes(model[idx], dat, sel);
         cpu_read_check("cpu read of mam data", idx);
         cpu_write("cpu write for mam", idx, 4'hF, next_random());
         mam_setup(wb_adr_t'(idx * 4), '0);
         mam_start(1'b0, 4'hF);
         mam_finish(1'b1, rd, err);
         check_value("mam read err", 0, err);
         check_value("mam rdata", model[idx], rd);
      end

      // MAM command while a CPU write is open
      idx = next_random() % `SRAM_WORDS;
      dat = next_random();
      mam_setup(wb_adr_t'(idx * 4), '0);
      fork
         cpu_access(1'b1, wb_adr_t'(idx * 4), 4'hF, dat, rd, err);
         mam_start(1'b0, 4'hF);
      join
      check_value("held cpu err", 0, err);
      model[idx] = dat;
      mam_finish(1'b1, rd, err);
      check_value("held mam err", 0, err);
      check_value("held cpu first", 1, mam_done_cycle > cpu_ack_cycle);
      check_value("mam read after cpu", model[idx], rd);

      // MAM and CPU start together, MAM goes first
      idx  = next_random() % `SRAM_WORDS;
      idx2 = (idx + 1) % `SRAM_WORDS;
      dat  = next_random();
      mam_setup(wb_adr_t'(idx * 4), dat);
      fork
         mam_start(1'b1, 4'hF);
         begin
            repeat (2) @(posedge clk);
            cpu_access(1'b0, wb_adr_t'(idx * 4), 4'hF, '0, rd, err);
         end
      join
      check_value("cpu err after mam", 0, err);
      model[idx] = dat;
      check_value("mam priority", 1, mam_done_cycle < cpu_ack_cycle);
      check_value("cpu read after mam", model[idx], rd);
      cpu_read_check("neighbour word", idx2);

      // Out-of-range accesses from both masters
      idx = next_random() % `SRAM_WORDS;
      cpu_access(1'b1, wb_adr_t'((`SRAM_WORDS + idx) * 4), 4'hF, next_random(), rd, err);
      check_value("cpu out of range err", 1, err);
      cpu_read_check("alias after cpu err", idx);
      mam_setup(wb_adr_t'((`SRAM_WORDS + idx) * 4), next_random());
      mam_start(1'b1, 4'hF);
      mam_finish(1'b1, rd, err);
      check_value("mam out of range err", 1, err);
      cpu_read_check("alias after mam err", idx);

      // Unmapped APB offset
      apb_access(1'b0, 8'h14, '0, rd, err);
      check_value("unmapped pslverr", 1, err);

      $display("TEST OK");
      $finish;
   end

endmodule
